/* sources.f */
+incdir+design
design/aluPkg.sv
design/operandPrep.sv
design/rippleAdder.sv
design/logicUnit.sv
design/resultSelect.sv
design/alu.sv
testbench/aluTb.sv

/* testbench/aluTb.sv */
/*
  ALU testbench
  directed table vectors followed by LFSR-driven random vectors,
  each checked against a reference model of the command rules
*/
`timescale 1ns/1ps
`include "alu_defs.svh"

module aluTb;

  localparam int RANDOM_LEN = 64;

  logic                  clk;
  logic [31:0]           operandA;
  logic [31:0]           operandB;
  logic [`CMD_WIDTH-1:0] command;
  logic [31:0]           result;
  logic                  carryOut;
  logic                  zero;
  logic                  overflow;

  int          cycleCount = 0;
  int          cycleLimit = 1000;
  int          testCount  = 0;
  int          passCount  = 0;
  int          failCount  = 0;
  logic [31:0] lfsrState;

  // directed vector table
  logic [31:0] tabA[$];
  logic [31:0] tabB[$];
  logic [2:0]  tabCmd[$];
  logic [31:0] tabRes[$];
  logic        tabCarry[$];
  logic        tabOvf[$];
  logic        tabZero[$];

  alu dut0 (
    .operandA (operandA),
    .operandB (operandB),
    .command  (command),
    .result   (result),
    .carryOut (carryOut),
    .zero     (zero),
    .overflow (overflow)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Test FAILED");
      $finish;
    end
  end

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one step per bit taken
  task automatic takeBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value     = {value[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
  endtask

  function automatic string cmdName(input logic [2:0] cmd);
    case (cmd)
      `ADD_OP:  return "add";
      `SUB_OP:  return "sub";
      `XOR_OP:  return "xor";
      `SLT_OP:  return "slt";
      `AND_OP:  return "and";
      `NAND_OP: return "nand";
      `NOR_OP:  return "nor";
      default:  return "or";
    endcase
  endfunction

  task automatic computeExpected(input logic [31:0] a, input logic [31:0] b,
                                 input logic [2:0] cmd, output logic [31:0] res,
                                 output logic c, output logic v, output logic z);
    logic [32:0] wide;
    res  = '0;
    c    = 1'b0;
    v    = 1'b0;
    wide = '0;
    case (cmd)
      `ADD_OP: begin
        wide = {1'b0, a} + {1'b0, b};
        res  = wide[31:0];
        c    = wide[32];
        v    = (a[31] == b[31]) && (res[31] != a[31]);
      end
      `SUB_OP: begin
        res = a - b;
        c   = (a >= b);
        v   = (a[31] != b[31]) && (res[31] != a[31]);
      end
      `XOR_OP:  res = a ^ b;
      `SLT_OP:  res = {31'd0, ($signed(a) < $signed(b))};
      `AND_OP:  res = a & b;
      `NAND_OP: res = ~(a & b);
      `NOR_OP:  res = ~(a | b);
      default:  res = a | b;
    endcase
    z = (res == 32'd0);
  endtask

  task automatic addRow(input logic [31:0] a, input logic [31:0] b, input logic [2:0] cmd,
                        input logic [31:0] res, input logic c, input logic v,
                        input logic z);
    tabA.push_back(a);
    tabB.push_back(b);
    tabCmd.push_back(cmd);
    tabRes.push_back(res);
    tabCarry.push_back(c);
    tabOvf.push_back(v);
    tabZero.push_back(z);
  endtask

  task automatic loadTable();
    addRow(32'h0000_0001, 32'h0000_0002, `ADD_OP,  32'h0000_0003, 1'b0, 1'b0, 1'b0);
    addRow(32'hFFFF_FFFF, 32'h0000_0001, `ADD_OP,  32'h0000_0000, 1'b1, 1'b0, 1'b1);
    addRow(32'h7FFF_FFFF, 32'h0000_0001, `ADD_OP,  32'h8000_0000, 1'b0, 1'b1, 1'b0);
    addRow(32'h8000_0000, 32'h8000_0000, `ADD_OP,  32'h0000_0000, 1'b1, 1'b1, 1'b1);
    addRow(32'h0000_0005, 32'h0000_0003, `SUB_OP,  32'h0000_0002, 1'b1, 1'b0, 1'b0);
    addRow(32'h0000_0003, 32'h0000_0005, `SUB_OP,  32'hFFFF_FFFE, 1'b0, 1'b0, 1'b0);
    addRow(32'h1234_5678, 32'h1234_5678, `SUB_OP,  32'h0000_0000, 1'b1, 1'b0, 1'b1);
    addRow(32'h8000_0000, 32'h0000_0001, `SUB_OP,  32'h7FFF_FFFF, 1'b1, 1'b1, 1'b0);
    addRow(32'hF0F0_F0F0, 32'h0FF0_0FF0, `XOR_OP,  32'hFF00_FF00, 1'b0, 1'b0, 1'b0);
    addRow(32'hA5A5_A5A5, 32'hA5A5_A5A5, `XOR_OP,  32'h0000_0000, 1'b0, 1'b0, 1'b1);
    addRow(32'hFFFF_FFFF, 32'h0000_0001, `SLT_OP,  32'h0000_0001, 1'b0, 1'b0, 1'b0);
    addRow(32'h0000_0001, 32'hFFFF_FFFF, `SLT_OP,  32'h0000_0000, 1'b0, 1'b0, 1'b1);
    // slt across signed overflow
    addRow(32'h8000_0000, 32'h7FFF_FFFF, `SLT_OP,  32'h0000_0001, 1'b0, 1'b0, 1'b0);
    addRow(32'hFF00_FF00, 32'h0F0F_0F0F, `AND_OP,  32'h0F00_0F00, 1'b0, 1'b0, 1'b0);
    addRow(32'hAAAA_AAAA, 32'h5555_5555, `AND_OP,  32'h0000_0000, 1'b0, 1'b0, 1'b1);
    addRow(32'hFFFF_0000, 32'hFF00_FF00, `NAND_OP, 32'h00FF_FFFF, 1'b0, 1'b0, 1'b0);
    addRow(32'hF000_0000, 32'h0F00_0000, `NOR_OP,  32'h00FF_FFFF, 1'b0, 1'b0, 1'b0);
    addRow(32'h1234_0000, 32'h0000_5678, `OR_OP,   32'h1234_5678, 1'b0, 1'b0, 1'b0);
    addRow(32'h0000_0000, 32'h0000_0000, `OR_OP,   32'h0000_0000, 1'b0, 1'b0, 1'b1);
  endtask

  // drive on the falling edge, check on the next rising edge
  task automatic applyVector(input logic [31:0] a, input logic [31:0] b,
                             input logic [2:0] cmd, input logic [31:0] expRes,
                             input logic expC, input logic expV, input logic expZ);
    int errors;
    errors = 0;
    @(negedge clk);
    operandA = a;
    operandB = b;
    command  = cmd;
    @(posedge clk);
    if (result !== expRes) begin
      $display("FAILED result: expected %h, got %h", expRes, result);
      errors++;
    end
    if (carryOut !== expC) begin
      $display("FAILED carryOut: expected %h, got %h", expC, carryOut);
      errors++;
    end
    if (overflow !== expV) begin
      $display("FAILED overflow: expected %h, got %h", expV, overflow);
      errors++;
    end
    if (zero !== expZ) begin
      $display("FAILED zero: expected %h, got %h", expZ, zero);
      errors++;
    end
    testCount++;
    if (errors == 0) begin
      passCount++;
      $display("test %0d %s a=%h b=%h: ok", testCount, cmdName(cmd), a, b);
    end else begin
      failCount++;
      $display("test %0d %s a=%h b=%h: %0d mismatches", testCount, cmdName(cmd), a, b,
               errors);
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] cmdBits;
    logic [31:0] expRes;
    logic        expC;
    logic        expV;
    logic        expZ;
    operandA  = '0;
    operandB  = '0;
    command   = '0;
    lfsrState = 32'h6d96_70f7;
    loadTable();
    cycleLimit = (2 + tabA.size() + RANDOM_LEN) * 2 + 20;

    // idle in place of a reset period
    repeat (2) @(posedge clk);

    for (int i = 0; i < tabA.size(); i++) begin
      applyVector(tabA[i], tabB[i], tabCmd[i], tabRes[i], tabCarry[i], tabOvf[i],
                  tabZero[i]);
    end

    for (int i = 0; i < RANDOM_LEN; i++) begin
      takeBits(32, a);
      takeBits(32, b);
      takeBits(3, cmdBits);
      computeExpected(a, b, cmdBits[2:0], expRes, expC, expV, expZ);
      applyVector(a, b, cmdBits[2:0], expRes, expC, expV, expZ);
    end

    $display("tests run: %0d, passed: %0d, failed: %0d", testCount, passCount, failCount);
    if (failCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* design/alu.sv */
/*
  32-bit combinational ALU
  add, subtract, xor, set-less-than, and, nand, nor and or,
  with carry-out, overflow and zero flags
*/
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu
  import aluPkg::*;
(
  input  aluWord                operandA,
  input  aluWord                operandB,
  input  logic [`CMD_WIDTH-1:0] command,
  output aluWord                result,
  output logic                  carryOut,
  output logic                  zero,
  output logic                  overflow
);

  logic [`SEL_WIDTH-1:0] select;
  logic                  subtract;
  aluWord                condA;
  aluWord                condB;
  aluWord                sum;
  logic                  adderCarry;
  logic                  adderOverflow;
  aluWord                xorOut;
  aluWord                nandOut;
  aluWord                norOut;

  operandPrep prep0 (
    .command  (command),
    .operandA (operandA),
    .operandB (operandB),
    .select   (select),
    .subtract (subtract),
    .condA    (condA),
    .condB    (condB)
  );

  // subtract is the carry-in for two's complement
  rippleAdder adder0 (
    .a        (condA),
    .b        (condB),
    .carryIn  (subtract),
    .sum      (sum),
    .carryOut (adderCarry),
    .overflow (adderOverflow)
  );

  logicUnit logic0 (
    .a       (condA),
    .b       (condB),
    .xorOut  (xorOut),
    .nandOut (nandOut),
    .norOut  (norOut)
  );

  resultSelect select0 (
    .select        (select),
    .sum           (sum),
    .adderCarry    (adderCarry),
    .adderOverflow (adderOverflow),
    .xorOut        (xorOut),
    .nandOut       (nandOut),
    .norOut        (norOut),
    .result        (result),
    .carryOut      (carryOut),
    .zero          (zero),
    .overflow      (overflow)
  );

endmodule

/* design/resultSelect.sv */
/*
  ALU result stage
  set-less-than, result mux, carry and overflow gating, zero flag
*/
`timescale 1ns/1ps
`include "alu_defs.svh"

module resultSelect
  import aluPkg::*;
(
  input  logic [`SEL_WIDTH-1:0] select,
  input  aluWord                sum,
  input  logic                  adderCarry,
  input  logic                  adderOverflow,
  input  aluWord                xorOut,
  input  aluWord                nandOut,
  input  aluWord                norOut,
  output aluWord                result,
  output logic                  carryOut,
  output logic                  zero,
  output logic                  overflow
);

  aluWord sltWord;
  logic   adderSelected;

  // a < b when the difference is negative, corrected for overflow
  always_comb begin
    sltWord.bits    = '0;
    sltWord.bits[0] = sum.signedView.sign ^ adderOverflow;
  end

  // result mux
  always_comb begin
    case (select)
      `SEL_ADD: begin
        result = sum;
      end
      `SEL_XOR: begin
        result.bits = xorOut.bits;
      end
      `SEL_SLT: begin
        result.bits = sltWord.bits;
      end
      `SEL_NAND: begin
        result.bits = nandOut.bits;
      end
      `SEL_NOR: begin
        result.bits = norOut.bits;
      end
      default: begin
        result.bits = '0;
      end
    endcase
  end

  // flags only mean something for add and subtract
  assign adderSelected = (select == `SEL_ADD);
  assign carryOut      = adderCarry & adderSelected;
  assign overflow      = adderOverflow & adderSelected;

  assign zero = ~(result.signedView.sign | (|result.signedView.rest));

endmodule

/* design/logicUnit.sv */
/*
  ALU logic unit
  bitwise xor, nand and nor of the conditioned operands
*/
`timescale 1ns/1ps

module logicUnit
  import aluPkg::*;
(
  input  aluWord a,
  input  aluWord b,
  output aluWord xorOut,
  output aluWord nandOut,
  output aluWord norOut
);

  assign xorOut.bits = a.bits ^ b.bits;

  // with both operands inverted this gives or
  assign nandOut.bits = ~(a.bits & b.bits);

  // with both operands inverted this gives and
  assign norOut.bits = ~(a.bits | b.bits);

endmodule

/* design/rippleAdder.sv */
/*
  ALU ripple-carry adder
  chain of full-adder stages with carry-out and signed overflow
*/
`timescale 1ns/1ps
`include "alu_defs.svh"

module rippleAdder
  import aluPkg::*;
(
  input  aluWord a,
  input  aluWord b,
  input  logic   carryIn,
  output aluWord sum,
  output logic   carryOut,
  output logic   overflow
);

  logic [`ALU_WIDTH:0]   carryChain;
  logic [`ALU_WIDTH-1:0] sumBits;

  assign carryChain[0] = carryIn;

  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : stage
    logic aBit;
    logic bBit;
    logic halfSum;

    // top stage works on the sign bits
    if (i == `ALU_WIDTH - 1) begin : signBit
      assign aBit = a.signedView.sign;
      assign bBit = b.signedView.sign;
    end else begin : lowBit
      assign aBit = a.signedView.rest[i];
      assign bBit = b.signedView.rest[i];
    end

    assign halfSum         = aBit ^ bBit;
    assign sumBits[i]      = halfSum ^ carryChain[i];
    assign carryChain[i+1] = (halfSum & carryChain[i]) | (aBit & bBit);
  end

  assign sum.bits = sumBits;
  assign carryOut = carryChain[`ALU_WIDTH];

  // carry into the sign stage differs from carry out of it
  assign overflow = carryChain[`ALU_WIDTH-1] ^ carryChain[`ALU_WIDTH];

endmodule

/* design/operandPrep.sv */
/*
  ALU operand preparation
  decodes the command into a result select and two invert
  controls, then conditionally inverts both operands
*/
`timescale 1ns/1ps
`include "alu_defs.svh"

module operandPrep
  import aluPkg::*;
(
  input  logic [`CMD_WIDTH-1:0] command,
  input  aluWord                operandA,
  input  aluWord                operandB,
  output logic [`SEL_WIDTH-1:0] select,
  output logic                  subtract,
  output aluWord                condA,
  output aluWord                condB
);

  logic invertA;

  // command lookup
  always_comb begin
    select   = `SEL_ADD;
    invertA  = 1'b0;
    subtract = 1'b0;
    case (command)
      `ADD_OP: begin
        select = `SEL_ADD;
      end
      `SUB_OP: begin
        select   = `SEL_ADD;
        subtract = 1'b1;
      end
      `XOR_OP: begin
        select = `SEL_XOR;
      end
      `SLT_OP: begin
        select   = `SEL_SLT;
        subtract = 1'b1;
      end
      // and is nor of inverted operands
      `AND_OP: begin
        select   = `SEL_NOR;
        invertA  = 1'b1;
        subtract = 1'b1;
      end
      `NAND_OP: begin
        select = `SEL_NAND;
      end
      `NOR_OP: begin
        select = `SEL_NOR;
      end
      // or is nand of inverted operands
      `OR_OP: begin
        select   = `SEL_NAND;
        invertA  = 1'b1;
        subtract = 1'b1;
      end
      default: begin
        select = `SEL_ADD;
      end
    endcase
  end

  // invert-B doubles as subtract
  assign condA.bits = operandA.bits ^ {`ALU_WIDTH{invertA}};
  assign condB.bits = operandB.bits ^ {`ALU_WIDTH{subtract}};

endmodule

/* design/aluPkg.sv */
/*
  ALU package
  data word seen either flat or as sign plus lower bits
*/
`include "alu_defs.svh"

package aluPkg;

  typedef union packed {
    logic [`ALU_WIDTH-1:0] bits;
    struct packed {
      logic                  sign;
      logic [`ALU_WIDTH-2:0] rest;
    } signedView;
  } aluWord;

endpackage

/* design/alu_defs.svh */
/*
  ALU shared definitions
  word widths, command codes and result-select codes
*/
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// widths
`define ALU_WIDTH 32
`define CMD_WIDTH 3
`define SEL_WIDTH 3

// command codes
`define ADD_OP  3'd0
`define SUB_OP  3'd1
`define XOR_OP  3'd2
`define SLT_OP  3'd3
`define AND_OP  3'd4
`define NAND_OP 3'd5
`define NOR_OP  3'd6
`define OR_OP   3'd7

// result select codes
`define SEL_ADD  3'd0
`define SEL_XOR  3'd1
`define SEL_SLT  3'd2
`define SEL_NAND 3'd3
`define SEL_NOR  3'd4

`endif
